// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Access width of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } memop_type_e;

endpackage

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int LINE_BYTES  = 16;
    localparam int NUM_LINES   = 16;

    // Address split for a 32-bit address
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(NUM_LINES);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    // Byte 0 of the line sits in bits [7:0]
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [INDEX_BITS-1:0]   index_t;

    typedef enum logic [2:0] {
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_COMPLETE
    } cache_state_e;

endpackage

`default_nettype wire

// File: design/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align
    import core_pkg::*;
(
    input  word_t       word_i,
    input  logic [1:0]  offset_i,
    input  memop_type_e type_i,
    input  logic        sign_ext_i,
    output word_t       data_o
);

    word_t shifted;

    // Addressed byte or half moved down to bit 0
    assign shifted = word_i >> {offset_i, 3'b000};

    always_comb begin
        case (type_i)
            MEM_BYTE: begin
                data_o = {{24{sign_ext_i & shifted[7]}}, shifted[7:0]};
            end
            MEM_HALF: begin
                data_o = {{16{sign_ext_i & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                data_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array
    import cache_pkg::*;
(
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  index_t index_i,
    input  tag_t   tag_i,
    input  logic   we_i,
    input  logic   set_dirty_i,
    input  logic   mark_clean_i,
    output logic   hit_o,
    output logic   victim_dirty_o,
    output tag_t   victim_tag_o
);

    tag_t tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we_i) begin
            // New line arrives clean unless a store lands with it
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= set_dirty_i;
        end else if (set_dirty_i) begin
            dirty_q[index_i] <= 1'b1;
        end else if (mark_clean_i) begin
            dirty_q[index_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tags[index_i] <= tag_i;
        end
    end

    assign hit_o          = valid_q[index_i] && (tags[index_i] == tag_i);
    assign victim_dirty_o = valid_q[index_i] && dirty_q[index_i];
    assign victim_tag_o   = tags[index_i];

endmodule

`default_nettype wire

// File: design/dcache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array
    import core_pkg::*;
    import cache_pkg::*;
(
    input  logic                   clk_i,
    input  index_t                 index_i,
    input  logic [OFFSET_BITS-1:0] offset_i,
    input  logic                   refill_we_i,
    input  line_t                  refill_line_i,
    input  logic                   store_we_i,
    input  memop_type_e            store_type_i,
    input  word_t                  store_data_i,
    output word_t                  rd_word_o,
    output line_t                  victim_line_o
);

    line_t lines [NUM_LINES];
    line_t new_line;
    logic [3:0] lane_be;
    word_t lane_data;

    assign victim_line_o = lines[index_i];
    assign rd_word_o     = lines[index_i][offset_i[OFFSET_BITS-1:2]*32 +: 32];

    // Byte lanes touched by the store, data replicated to every lane
    always_comb begin
        lane_be   = 4'b1111;
        lane_data = store_data_i;
        case (store_type_i)
            MEM_BYTE: begin
                lane_be   = 4'b0001 << offset_i[1:0];
                lane_data = {4{store_data_i[7:0]}};
            end
            MEM_HALF: begin
                lane_be   = 4'b0011 << offset_i[1:0];
                lane_data = {2{store_data_i[15:0]}};
            end
            default: begin
                lane_be   = 4'b1111;
                lane_data = store_data_i;
            end
        endcase
    end

    // Store bytes go on top of the refill line when both are written
    always_comb begin
        new_line = refill_we_i ? refill_line_i : lines[index_i];
        if (store_we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_be[b]) begin
                    new_line[(offset_i[OFFSET_BITS-1:2]*4 + b)*8 +: 8] = lane_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_we_i || store_we_i) begin
            lines[index_i] <= new_line;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_ctrl
    import cache_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic req_valid_i,
    input  logic is_mem_i,
    input  logic hit_i,
    input  logic victim_dirty_i,
    input  logic mem_ready_i,
    output logic hold_en_o,
    output logic use_held_o,
    output logic tag_we_o,
    output logic refill_we_o,
    output logic store_en_o,
    output logic mem_rd_o,
    output logic mem_wr_o,
    output logic sel_victim_addr_o,
    output logic busy_o,
    output logic complete_o
);

    cache_state_e state_q;
    cache_state_e state_d;
    logic lookup;
    logic in_complete;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: begin
                // Dirty victims go out before the refill
                if (req_valid_i && is_mem_i && !hit_i) begin
                    state_d = victim_dirty_i ? ST_WRITEBACK : ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                state_d = ST_REFILL_REQ;
            end
            ST_REFILL_REQ: begin
                state_d = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                if (mem_ready_i) begin
                    state_d = ST_COMPLETE;
                end
            end
            ST_COMPLETE: begin
                state_d = ST_LOOKUP;
            end
            default: begin
                state_d = ST_LOOKUP;
            end
        endcase
    end

    assign lookup      = (state_q == ST_LOOKUP);
    assign in_complete = (state_q == ST_COMPLETE);

    // Latch every accepted request, only misses ever use it
    assign hold_en_o  = lookup && req_valid_i;
    assign use_held_o = !lookup;
    assign busy_o     = !lookup;

    assign mem_wr_o          = (state_q == ST_WRITEBACK);
    assign sel_victim_addr_o = (state_q == ST_WRITEBACK);
    assign mem_rd_o          = (state_q == ST_REFILL_REQ);

    // Refill line and its tag land on the ready edge
    assign refill_we_o = (state_q == ST_REFILL_WAIT) && mem_ready_i;
    assign tag_we_o    = refill_we_o;

    // Held store merges into the fresh line in the complete cycle
    assign store_en_o = (lookup && req_valid_i && hit_i) || in_complete;
    assign complete_o = (lookup && req_valid_i && (!is_mem_i || hit_i)) || in_complete;

    a_wait_after_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == ST_REFILL_WAIT) |->
            ($past(mem_rd_o) || $past(state_q == ST_REFILL_WAIT)));

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage
    import core_pkg::*;
    import cache_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Request from execute
    input  logic        req_valid_i,
    input  logic        memop_rd_i,
    input  logic        memop_wr_i,
    input  memop_type_e memop_type_i,
    input  logic        sign_ext_i,
    input  word_t       alu_res_i,
    input  word_t       st_data_i,
    input  logic        rf_we_i,
    input  reg_addr_t   rf_waddr_i,
    input  logic        tkbr_i,
    input  word_t       new_pc_i,
    input  logic        is_jal_i,
    input  word_t       seq_pc_i,
    output logic        busy_o,

    // To writeback
    output logic        wb_valid_o,
    output word_t       op_res_o,
    output logic        rf_we_o,
    output reg_addr_t   rf_waddr_o,
    output logic        tkbr_o,
    output word_t       new_pc_o,

    // Main memory
    output word_t       mem_addr_o,
    output logic        mem_rd_o,
    output logic        mem_wr_o,
    output line_t       mem_line_o,
    input  line_t       mem_line_i,
    input  logic        mem_ready_i
);

    logic hold_en;
    logic use_held;
    logic tag_we;
    logic refill_we;
    logic store_en;
    logic store_we;
    logic sel_victim;
    logic complete;
    logic hit;
    logic victim_dirty;
    tag_t victim_tag;
    word_t rd_word;
    word_t load_data;

    // Request held across a miss
    logic held_rd, held_wr, held_sign_ext, held_rf_we, held_tkbr, held_is_jal;
    memop_type_e held_type;
    word_t held_alu_res, held_st_data, held_new_pc, held_seq_pc;
    reg_addr_t held_rf_waddr;

    // Request seen by the cache this cycle
    logic req_rd, req_wr, req_sign_ext, req_rf_we, req_tkbr, req_is_jal;
    memop_type_e req_type;
    word_t req_alu_res, req_st_data, req_new_pc, req_seq_pc;
    reg_addr_t req_rf_waddr;
    tag_t req_tag;
    index_t req_index;
    logic [OFFSET_BITS-1:0] req_offset;

    always_ff @(posedge clk_i) begin
        if (hold_en) begin
            held_rd       <= memop_rd_i;
            held_wr       <= memop_wr_i;
            held_type     <= memop_type_i;
            held_sign_ext <= sign_ext_i;
            held_alu_res  <= alu_res_i;
            held_st_data  <= st_data_i;
            held_rf_we    <= rf_we_i;
            held_rf_waddr <= rf_waddr_i;
            held_tkbr     <= tkbr_i;
            held_new_pc   <= new_pc_i;
            held_is_jal   <= is_jal_i;
            held_seq_pc   <= seq_pc_i;
        end
    end

    assign req_rd       = use_held ? held_rd       : memop_rd_i;
    assign req_wr       = use_held ? held_wr       : memop_wr_i;
    assign req_type     = use_held ? held_type     : memop_type_i;
    assign req_sign_ext = use_held ? held_sign_ext : sign_ext_i;
    assign req_alu_res  = use_held ? held_alu_res  : alu_res_i;
    assign req_st_data  = use_held ? held_st_data  : st_data_i;
    assign req_rf_we    = use_held ? held_rf_we    : rf_we_i;
    assign req_rf_waddr = use_held ? held_rf_waddr : rf_waddr_i;
    assign req_tkbr     = use_held ? held_tkbr     : tkbr_i;
    assign req_new_pc   = use_held ? held_new_pc   : new_pc_i;
    assign req_is_jal   = use_held ? held_is_jal   : is_jal_i;
    assign req_seq_pc   = use_held ? held_seq_pc   : seq_pc_i;

    assign req_tag    = req_alu_res[31 -: TAG_BITS];
    assign req_index  = req_alu_res[OFFSET_BITS +: INDEX_BITS];
    assign req_offset = req_alu_res[OFFSET_BITS-1:0];

    assign store_we = store_en && req_wr;

    // Victim line address during writeback, miss line address otherwise
    assign mem_addr_o = {sel_victim ? victim_tag : req_tag, req_index, {OFFSET_BITS{1'b0}}};

    mem_stage_ctrl i_ctrl (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .req_valid_i       (req_valid_i),
        .is_mem_i          (req_rd || req_wr),
        .hit_i             (hit),
        .victim_dirty_i    (victim_dirty),
        .mem_ready_i       (mem_ready_i),
        .hold_en_o         (hold_en),
        .use_held_o        (use_held),
        .tag_we_o          (tag_we),
        .refill_we_o       (refill_we),
        .store_en_o        (store_en),
        .mem_rd_o          (mem_rd_o),
        .mem_wr_o          (mem_wr_o),
        .sel_victim_addr_o (sel_victim),
        .busy_o            (busy_o),
        .complete_o        (complete)
    );

    dcache_tag_array i_tags (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .index_i        (req_index),
        .tag_i          (req_tag),
        .we_i           (tag_we),
        .set_dirty_i    (store_we),
        .mark_clean_i   (mem_wr_o),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array i_data (
        .clk_i         (clk_i),
        .index_i       (req_index),
        .offset_i      (req_offset),
        .refill_we_i   (refill_we),
        .refill_line_i (mem_line_i),
        .store_we_i    (store_we),
        .store_type_i  (req_type),
        .store_data_i  (req_st_data),
        .rd_word_o     (rd_word),
        .victim_line_o (mem_line_o)
    );

    load_align i_align (
        .word_i     (rd_word),
        .offset_i   (req_offset[1:0]),
        .type_i     (req_type),
        .sign_ext_i (req_sign_ext),
        .data_o     (load_data)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= complete;
        end
    end

    always_ff @(posedge clk_i) begin
        if (complete) begin
            op_res_o   <= req_rd ? load_data : (req_is_jal ? req_seq_pc : req_alu_res);
            // Stores never write the register file
            rf_we_o    <= req_rf_we && !req_wr;
            rf_waddr_o <= req_rf_waddr;
            tkbr_o     <= req_tkbr;
            new_pc_o   <= req_new_pc;
        end
    end

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i |-> !busy_o);

    a_mem_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem_rd_o && mem_wr_o));

endmodule

`default_nettype wire

// File: test/main_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module main_mem_model
    import core_pkg::*;
    import cache_pkg::*;
(
    input  logic  clk_i,
    input  word_t addr_i,
    input  logic  rd_i,
    input  logic  wr_i,
    input  line_t line_i,
    output line_t line_o,
    output logic  ready_o
);

    // Lines written back so far, keyed by line address
    line_t lines [word_t];

    // Unwritten memory: each word is its byte address XOR a fixed pattern
    function automatic line_t initial_line(input word_t line_addr);
        line_t l;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*32 +: 32] = (line_addr + 4 * w) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    initial begin
        word_t rd_addr;
        int unsigned delay;
        ready_o = 1'b0;
        line_o  = '0;
        forever begin
            // Strobes are sampled mid-cycle where they are stable
            @(negedge clk_i);
            if (wr_i) begin
                lines[addr_i] = line_i;
            end
            if (rd_i) begin
                rd_addr = addr_i;
                delay   = $urandom_range(6, 1);
                repeat (delay) @(posedge clk_i);
                #1;
                line_o  = lines.exists(rd_addr) ? lines[rd_addr] : initial_line(rd_addr);
                ready_o = 1'b1;
                @(posedge clk_i);
                #1;
                ready_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage
    import core_pkg::*;
    import cache_pkg::*;
();

    localparam int          N_REQ   = 400;
    localparam int          TIMEOUT = 50;
    localparam int unsigned SEED    = 32'h4322_af22;

    logic clk;
    logic arst_n;

    logic        req_valid;
    logic        memop_rd;
    logic        memop_wr;
    memop_type_e memop_type;
    logic        sign_ext;
    word_t       alu_res;
    word_t       st_data;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    logic        tkbr;
    word_t       new_pc;
    logic        is_jal;
    word_t       seq_pc;
    logic        busy;
    logic        wb_valid;
    word_t       wb_op_res;
    logic        wb_rf_we;
    reg_addr_t   wb_rf_waddr;
    logic        wb_tkbr;
    word_t       wb_new_pc;
    word_t       mem_addr;
    logic        mem_rd;
    logic        mem_wr;
    line_t       mem_line_out;
    line_t       mem_line_in;
    logic        mem_ready;

    // Reference memory and a tag model of the direct-mapped cache
    logic [7:0] ref_mem [word_t];
    tag_t       model_tag [NUM_LINES];
    logic       model_valid [NUM_LINES];
    logic       model_dirty [NUM_LINES];
    word_t      exp_victim_addr;
    word_t      exp_miss_addr;
    int         wr_count = 0;
    int         rd_count = 0;
    time        wr_time;
    time        rd_time;
    int         n_req = 0;
    int         n_checks = 0;
    int         n_errors = 0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    mem_stage i_mem_stage (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .memop_rd_i   (memop_rd),
        .memop_wr_i   (memop_wr),
        .memop_type_i (memop_type),
        .sign_ext_i   (sign_ext),
        .alu_res_i    (alu_res),
        .st_data_i    (st_data),
        .rf_we_i      (rf_we),
        .rf_waddr_i   (rf_waddr),
        .tkbr_i       (tkbr),
        .new_pc_i     (new_pc),
        .is_jal_i     (is_jal),
        .seq_pc_i     (seq_pc),
        .busy_o       (busy),
        .wb_valid_o   (wb_valid),
        .op_res_o     (wb_op_res),
        .rf_we_o      (wb_rf_we),
        .rf_waddr_o   (wb_rf_waddr),
        .tkbr_o       (wb_tkbr),
        .new_pc_o     (wb_new_pc),
        .mem_addr_o   (mem_addr),
        .mem_rd_o     (mem_rd),
        .mem_wr_o     (mem_wr),
        .mem_line_o   (mem_line_out),
        .mem_line_i   (mem_line_in),
        .mem_ready_i  (mem_ready)
    );

    main_mem_model i_main_mem (
        .clk_i   (clk),
        .addr_i  (mem_addr),
        .rd_i    (mem_rd),
        .wr_i    (mem_wr),
        .line_i  (mem_line_out),
        .line_o  (mem_line_in),
        .ready_o (mem_ready)
    );

    task automatic check_value(input string name, input line_t got, input line_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s: got %0h, expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [7:0] ref_byte(input word_t addr);
        word_t init_word;
        init_word = {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return init_word[addr[1:0]*8 +: 8];
    endfunction

    function automatic line_t ref_line(input word_t line_addr);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = ref_byte(line_addr + b);
        end
        return l;
    endfunction

    // Little-endian load with optional sign extension
    function automatic word_t load_value(input word_t addr, input memop_type_e t, input logic sx);
        word_t v;
        case (t)
            MEM_BYTE: begin
                v = {24'h0, ref_byte(addr)};
                if (sx && v[7]) v[31:8] = '1;
            end
            MEM_HALF: begin
                v = {16'h0, ref_byte(addr + 1), ref_byte(addr)};
                if (sx && v[15]) v[31:16] = '1;
            end
            default: begin
                v = {ref_byte(addr + 3), ref_byte(addr + 2), ref_byte(addr + 1), ref_byte(addr)};
            end
        endcase
        return v;
    endfunction

    task automatic store_ref(input word_t addr, input memop_type_e t, input word_t data);
        int n;
        n = (t == MEM_BYTE) ? 1 : ((t == MEM_HALF) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            ref_mem[addr + i] = data[i*8 +: 8];
        end
    endtask

    // Few tags over few indexes so that lines conflict often
    function automatic tag_t pick_tag(input int unsigned sel);
        case (sel)
            0: return 24'h000010;
            1: return 24'h0abcde;
            default: return 24'h000011;
        endcase
    endfunction

    // Memory strobes checked against the model in the middle of the cycle
    always @(negedge clk) begin
        if (arst_n && mem_wr) begin
            wr_count++;
            wr_time = $time;
            check_value("mem_addr_o", mem_addr, exp_victim_addr);
            check_value("mem_line_o", mem_line_out, ref_line(exp_victim_addr));
        end
        if (arst_n && mem_rd) begin
            rd_count++;
            rd_time = $time;
            check_value("mem_addr_o", mem_addr, exp_miss_addr);
        end
    end

    task automatic wait_idle(output bit ok);
        int cnt;
        cnt = 0;
        while (busy && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        ok = !busy;
        if (!ok) begin
            n_errors++;
            $display("Timeout: busy_o stayed high for %0d cycles", TIMEOUT);
        end
    endtask

    // Latency counts edges from the request edge to the edge that sees the strobe
    task automatic wait_wb(output bit ok, output int lat);
        lat = 1;
        while (!wb_valid && lat <= TIMEOUT) begin
            @(posedge clk);
            #1;
            lat++;
        end
        ok = wb_valid;
        if (!ok) begin
            n_errors++;
            $display("Timeout: no wb_valid_o within %0d cycles of a request", TIMEOUT);
        end
    endtask

    task automatic issue_request(output bit ok);
        int unsigned kind;
        memop_type_e mtype;
        index_t idx;
        tag_t tg;
        logic [3:0] off;
        bit is_mem;
        bit hit;
        bit dirty_victim;
        int wr_before;
        int rd_before;
        int lat;
        word_t exp_res;
        wait_idle(ok);
        if (!ok) return;
        kind = $urandom_range(9, 0);
        case ($urandom_range(2, 0))
            0: mtype = MEM_BYTE;
            1: mtype = MEM_HALF;
            default: mtype = MEM_WORD;
        endcase
        tg  = pick_tag($urandom_range(2, 0));
        idx = $urandom_range(3, 0);
        off = $urandom_range(15, 0);
        if (mtype == MEM_HALF) off[0] = 1'b0;
        if (mtype == MEM_WORD) off[1:0] = 2'b00;
        memop_rd   = (kind < 4);
        memop_wr   = (kind >= 4 && kind < 7);
        is_mem     = memop_rd || memop_wr;
        memop_type = mtype;
        sign_ext   = $urandom_range(1, 0);
        alu_res    = is_mem ? {tg, idx, off} : $urandom();
        st_data    = $urandom();
        rf_we      = $urandom_range(1, 0);
        rf_waddr   = $urandom_range(31, 0);
        tkbr       = $urandom_range(1, 0);
        new_pc     = $urandom();
        is_jal     = is_mem ? 1'b0 : $urandom_range(1, 0);
        seq_pc     = $urandom();

        hit             = model_valid[idx] && (model_tag[idx] == tg);
        dirty_victim    = model_valid[idx] && model_dirty[idx];
        exp_victim_addr = {model_tag[idx], idx, 4'h0};
        exp_miss_addr   = {tg, idx, 4'h0};
        if (memop_rd) exp_res = load_value(alu_res, mtype, sign_ext);
        else          exp_res = is_jal ? seq_pc : alu_res;
        wr_before = wr_count;
        rd_before = rd_count;

        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        wait_wb(ok, lat);
        if (!ok) return;

        check_value("busy_o", busy, 1'b0);
        check_value("op_res_o", wb_op_res, exp_res);
        check_value("rf_we_o", wb_rf_we, rf_we && !memop_wr);
        check_value("rf_waddr_o", wb_rf_waddr, rf_waddr);
        check_value("tkbr_o", wb_tkbr, tkbr);
        check_value("new_pc_o", wb_new_pc, new_pc);
        if (!is_mem || hit) begin
            check_value("wb_valid_o latency", lat, 1);
            check_value("mem_rd_o count", rd_count, rd_before);
            check_value("mem_wr_o count", wr_count, wr_before);
        end else begin
            check_value("mem_rd_o count", rd_count, rd_before + 1);
            check_value("mem_wr_o count", wr_count, wr_before + dirty_victim);
            if (dirty_victim) check_value("mem_wr_o before mem_rd_o", wr_time < rd_time, 1'b1);
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tg;
            model_dirty[idx] = 1'b0;
        end
        if (memop_wr) begin
            model_dirty[idx] = 1'b1;
            store_ref(alu_res, mtype, st_data);
        end

        // Strobe lasts a single cycle
        @(posedge clk);
        #1;
        check_value("wb_valid_o", wb_valid, 1'b0);
    endtask

    initial begin
        bit ok;
        int unsigned seed_ret;
        seed_ret   = $urandom(SEED);
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        memop_rd   = 1'b0;
        memop_wr   = 1'b0;
        memop_type = MEM_WORD;
        sign_ext   = 1'b0;
        alu_res    = '0;
        st_data    = '0;
        rf_we      = 1'b0;
        rf_waddr   = '0;
        tkbr       = 1'b0;
        new_pc     = '0;
        is_jal     = 1'b0;
        seq_pc     = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Idle outputs after reset
        repeat (3) begin
            check_value("busy_o", busy, 1'b0);
            check_value("wb_valid_o", wb_valid, 1'b0);
            check_value("mem_rd_o", mem_rd, 1'b0);
            check_value("mem_wr_o", mem_wr, 1'b0);
            @(posedge clk);
            #1;
        end

        ok = 1'b1;
        for (int i = 0; i < N_REQ && ok; i++) begin
            issue_request(ok);
            n_req++;
        end

        $display("Requests: %0d, checks: %0d, errors: %0d", n_req, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/core_pkg.sv
design/cache_pkg.sv
design/load_align.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/mem_stage_ctrl.sv
design/mem_stage.sv
test/main_mem_model.sv
test/tb_mem_stage.sv
